/* design/matmul_pkg.sv */
`default_nettype none

package matmul_pkg;

  // Element and bus widths
  localparam int DATA_WIDTH   = 8;
  localparam int ADDR_WIDTH   = 11;
  localparam int STRIDE_WIDTH = 8;
  localparam int CNT_WIDTH    = 8;

  // Operand register, product register and accumulator inside each PE
  localparam int MAC_LATENCY = 3;
  // Operand memories answer one cycle after the address
  localparam int MEM_LATENCY = 1;

  typedef logic signed [DATA_WIDTH-1:0]   data_t;
  typedef logic signed [2*DATA_WIDTH-1:0] product_t;
  typedef logic [ADDR_WIDTH-1:0]          addr_t;
  typedef logic [STRIDE_WIDTH-1:0]        stride_t;
  typedef logic [CNT_WIDTH-1:0]           cnt_t;

  // Sequencer states; HOLD waits for start to drop after done
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DONE,
    SEQ_HOLD
  } seq_state_t;

endpackage

`default_nettype wire

/* design/processing_element.sv */
`timescale 1ns/100ps
`default_nettype none

module processing_element (
  input  logic              clk,
  input  logic              i_clear,
  input  matmul_pkg::data_t i_a,
  input  matmul_pkg::data_t i_b,
  output matmul_pkg::data_t o_a,
  output matmul_pkg::data_t o_b,
  output matmul_pkg::data_t o_sum
);
  import matmul_pkg::*;

  // Saturation limits of one element, held at product width for the compare
  localparam product_t SAT_MAX = product_t'(2 ** (DATA_WIDTH - 1) - 1);
  localparam product_t SAT_MIN = product_t'(-(2 ** (DATA_WIDTH - 1)));

  data_t    pass_a_q;
  data_t    pass_b_q;
  data_t    a_q;
  data_t    b_q;
  product_t prod_q;
  data_t    prod_sat;
  data_t    acc_q;

  //////////////////////////////////////////////////
  // Operand pass and MAC pipeline
  //////////////////////////////////////////////////

  // Everything clears so a pe_reset leaves no stale product in flight
  always_ff @(posedge clk) begin
    if (i_clear) begin
      pass_a_q <= '0;
      pass_b_q <= '0;
      a_q      <= '0;
      b_q      <= '0;
      prod_q   <= '0;
      acc_q    <= '0;
    end else begin
      pass_a_q <= i_a;
      pass_b_q <= i_b;
      a_q      <= i_a;
      b_q      <= i_b;
      // Both operands signed, so the full product sign extends correctly
      prod_q   <= a_q * b_q;
      // Sum wraps at element width
      acc_q    <= acc_q + prod_sat;
    end
  end

  // Clamp the registered product back to one element
  always_comb begin
    if (prod_q > SAT_MAX) begin
      prod_sat = data_t'(SAT_MAX);
    end else if (prod_q < SAT_MIN) begin
      prod_sat = data_t'(SAT_MIN);
    end else begin
      prod_sat = data_t'(prod_q);
    end
  end

  assign o_a   = pass_a_q;
  assign o_b   = pass_b_q;
  assign o_sum = acc_q;

endmodule

`default_nettype wire

/* design/pe_array.sv */
`timescale 1ns/100ps
`default_nettype none

module pe_array #(
  parameter int MAT_SIZE = 4
) (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic                                                i_pe_reset,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]          i_a_lanes,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]          i_b_lanes,
  output logic [MAT_SIZE*MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] o_sums
);
  import matmul_pkg::*;

  // Column 0 of a_link and row 0 of b_link come from the lanes, the last
  // column and row catch the edge outputs and go nowhere
  data_t a_link [MAT_SIZE][MAT_SIZE+1];
  data_t b_link [MAT_SIZE+1][MAT_SIZE];
  logic  pe_clear;

  assign pe_clear = reset || i_pe_reset;

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_edge
    assign a_link[i][0] = data_t'(i_a_lanes[i*DATA_WIDTH +: DATA_WIDTH]);
    assign b_link[0][i] = data_t'(i_b_lanes[i*DATA_WIDTH +: DATA_WIDTH]);
  end

  //////////////////////////////////////////////////
  // Grid
  //////////////////////////////////////////////////

  // A moves right along a row, B moves down a column
  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      processing_element u_pe (
        .clk     (clk),
        .i_clear (pe_clear),
        .i_a     (a_link[i][j]),
        .i_b     (b_link[i][j]),
        .o_a     (a_link[i][j+1]),
        .o_b     (b_link[i+1][j]),
        // Sum of row i, column j sits at index i*N+j
        .o_sum   (o_sums[(i*MAT_SIZE+j)*DATA_WIDTH +: DATA_WIDTH])
      );
    end
  end

endmodule

`default_nettype wire

/* design/operand_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_fetch #(
  parameter int MAT_SIZE = 4
) (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       i_running,
  input  matmul_pkg::cnt_t                           i_run_cnt,
  input  matmul_pkg::addr_t                          i_base,
  input  matmul_pkg::stride_t                        i_stride,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_mem_data,
  output matmul_pkg::addr_t                          o_mem_addr,
  output logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] o_lanes
);
  import matmul_pkg::*;

  addr_t                  addr_q;
  logic                   access_q;
  logic [MEM_LATENCY-1:0] valid_sr;
  logic                   data_valid;

  //////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////

  // Base goes out in cycle 1, then one stride per cycle up to cycle N
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q   <= '0;
      access_q <= 1'b0;
    end else begin
      access_q <= i_running && (i_run_cnt < cnt_t'(MAT_SIZE));
      if (i_running && (i_run_cnt == '0)) begin
        addr_q <= i_base;
      end else if (i_running && (i_run_cnt < cnt_t'(MAT_SIZE))) begin
        addr_q <= addr_q + addr_t'(i_stride);
      end
    end
  end

  assign o_mem_addr = addr_q;

  // Read data trails the access flag by the memory latency
  always_ff @(posedge clk) begin
    if (reset || !i_running) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= (valid_sr << 1) | MEM_LATENCY'(access_q);
    end
  end

  assign data_valid = valid_sr[MEM_LATENCY-1];

  //////////////////////////////////////////////////
  // Diagonal skew
  //////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_lane
    data_t word_lane;

    // Zero outside the valid window so idle cycles add nothing in the PEs
    assign word_lane = data_valid ? data_t'(i_mem_data[i*DATA_WIDTH +: DATA_WIDTH]) : '0;

    if (i == 0) begin : g_direct
      assign o_lanes[0 +: DATA_WIDTH] = word_lane;
    end else begin : g_skew
      // Lane i lags lane 0 by i cycles
      data_t chain_q [i];

      always_ff @(posedge clk) begin
        if (reset || !i_running) begin
          for (int s = 0; s < i; s++) begin
            chain_q[s] <= '0;
          end
        end else begin
          chain_q[0] <= word_lane;
          for (int s = 1; s < i; s++) begin
            chain_q[s] <= chain_q[s-1];
          end
        end
      end

      assign o_lanes[i*DATA_WIDTH +: DATA_WIDTH] = chain_q[i-1];
    end
  end

  // One access window of exactly N words per run
  a_access_len : assert property (@(posedge clk) disable iff (reset)
    $rose(access_q) |-> access_q [*MAT_SIZE] ##1 !access_q);

endmodule

`default_nettype wire

/* design/matmul_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module matmul_sequencer #(
  parameter int MAT_SIZE = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             i_start,
  output matmul_pkg::cnt_t o_run_cnt,
  output logic             o_running,
  output logic             o_latch,
  output logic             o_done
);
  import matmul_pkg::*;

  // Last operand enters the far corner PE in cycle 3N-1 and lands in its sum
  // MAC_LATENCY cycles later, which is the cycle the results are latched
  localparam cnt_t LATCH_CNT =
    cnt_t'(1 + MEM_LATENCY + 3 * (MAT_SIZE - 1) + MAC_LATENCY);
  // Count of the cycle that shows the last column
  localparam cnt_t LAST_COL_CNT = cnt_t'(LATCH_CNT + MAT_SIZE);

  seq_state_t state_q;
  cnt_t       cnt_q;

  //////////////////////////////////////////////////
  // Cycle counter and state machine
  //////////////////////////////////////////////////

  // Dropping start aborts whatever is in flight
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      state_q <= SEQ_IDLE;
      cnt_q   <= '0;
    end else begin
      // Counter stops in HOLD so a long start level never wraps it
      if (state_q != SEQ_HOLD) begin
        cnt_q <= cnt_q + 1'b1;
      end
      case (state_q)
        SEQ_IDLE: state_q <= SEQ_RUN;
        SEQ_RUN: begin
          if (cnt_q == LAST_COL_CNT) begin
            state_q <= SEQ_DONE;
          end
        end
        SEQ_DONE: state_q <= SEQ_HOLD;
        default:  state_q <= SEQ_HOLD;
      endcase
    end
  end

  // Count equals the cycle number since start went high
  assign o_run_cnt = cnt_q;
  assign o_running = i_start && (state_q != SEQ_HOLD);
  assign o_latch   = (state_q == SEQ_RUN) && (cnt_q == LATCH_CNT);
  assign o_done    = (state_q == SEQ_DONE);

  // Done is a single pulse per operation
  a_done_single : assert property (@(posedge clk) disable iff (reset)
    o_done |=> !o_done);

endmodule

`default_nettype wire

/* design/result_drain.sv */
`timescale 1ns/100ps
`default_nettype none

module result_drain #(
  parameter int MAT_SIZE = 4
) (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic                                                i_running,
  input  logic                                                i_latch,
  input  matmul_pkg::addr_t                                   i_addr_c,
  input  matmul_pkg::stride_t                                 i_stride_c,
  input  logic [MAT_SIZE*MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_sums,
  output logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]          o_c_data,
  output matmul_pkg::addr_t                                   o_c_addr,
  output logic                                                o_c_valid
);
  import matmul_pkg::*;

  localparam int ROW_W = MAT_SIZE * DATA_WIDTH;
  localparam int CW    = $clog2(MAT_SIZE + 1);

  logic [ROW_W-1:0] sum_col [MAT_SIZE];
  logic [ROW_W-1:0] col_q   [MAT_SIZE];
  addr_t            addr_q;
  logic [CW-1:0]    left_q;
  logic             valid_q;

  // Gather column j of C with row i in lane i
  for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
    for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
      assign sum_col[j][i*DATA_WIDTH +: DATA_WIDTH] =
        i_sums[(i*MAT_SIZE+j)*DATA_WIDTH +: DATA_WIDTH];
    end
  end

  //////////////////////////////////////////////////
  // Column shifter
  //////////////////////////////////////////////////

  // Column registers carry data only, the valid count decides what counts
  always_ff @(posedge clk) begin
    if (i_latch) begin
      col_q  <= sum_col;
      addr_q <= i_addr_c;
    end else if (valid_q) begin
      for (int j = 0; j < MAT_SIZE - 1; j++) begin
        col_q[j] <= col_q[j+1];
      end
      col_q[MAT_SIZE-1] <= '0;
      addr_q <= addr_q + addr_t'(i_stride_c);
    end
  end

  // N columns leave back to back after the strobe
  always_ff @(posedge clk) begin
    if (reset || !i_running) begin
      valid_q <= 1'b0;
      left_q  <= '0;
    end else if (i_latch) begin
      valid_q <= 1'b1;
      left_q  <= CW'(MAT_SIZE - 1);
    end else if (valid_q) begin
      if (left_q == '0) begin
        valid_q <= 1'b0;
      end else begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  assign o_c_data  = col_q[0];
  assign o_c_addr  = addr_q;
  assign o_c_valid = valid_q;

  // No burst longer than one matrix worth of columns
  a_valid_len : assert property (@(posedge clk) disable iff (reset)
    o_c_valid [*MAT_SIZE] |=> !o_c_valid);

endmodule

`default_nettype wire

/* design/systolic_matmul.sv */
`timescale 1ns/100ps
`default_nettype none

module systolic_matmul #(
  parameter int MAT_SIZE = 4
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         i_start,
  input  logic                                         i_pe_reset,
  input  matmul_pkg::addr_t                            i_addr_a,
  input  matmul_pkg::addr_t                            i_addr_b,
  input  matmul_pkg::addr_t                            i_addr_c,
  input  matmul_pkg::stride_t                          i_stride_a,
  input  matmul_pkg::stride_t                          i_stride_b,
  input  matmul_pkg::stride_t                          i_stride_c,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]   i_a_data,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]   i_b_data,
  output matmul_pkg::addr_t                            o_a_addr,
  output matmul_pkg::addr_t                            o_b_addr,
  output matmul_pkg::addr_t                            o_c_addr,
  output logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]   o_c_data,
  output logic                                         o_c_valid,
  output logic                                         o_done
);
  import matmul_pkg::*;

  // Sequencer to fetch and drain
  cnt_t run_cnt;
  logic running;
  logic latch;

  // Skewed operand lanes into the grid and all sums back out
  logic [MAT_SIZE*DATA_WIDTH-1:0]          a_lanes;
  logic [MAT_SIZE*DATA_WIDTH-1:0]          b_lanes;
  logic [MAT_SIZE*MAT_SIZE*DATA_WIDTH-1:0] sums;

  matmul_sequencer #(.MAT_SIZE(MAT_SIZE)) u_sequencer (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .o_run_cnt (run_cnt),
    .o_running (running),
    .o_latch   (latch),
    .o_done    (o_done)
  );

  // A words hold one column of A, so lane i feeds row i of the grid
  operand_fetch #(.MAT_SIZE(MAT_SIZE)) u_fetch_a (
    .clk        (clk),
    .reset      (reset),
    .i_running  (running),
    .i_run_cnt  (run_cnt),
    .i_base     (i_addr_a),
    .i_stride   (i_stride_a),
    .i_mem_data (i_a_data),
    .o_mem_addr (o_a_addr),
    .o_lanes    (a_lanes)
  );

  // B words hold one row of B, so lane j feeds column j of the grid
  operand_fetch #(.MAT_SIZE(MAT_SIZE)) u_fetch_b (
    .clk        (clk),
    .reset      (reset),
    .i_running  (running),
    .i_run_cnt  (run_cnt),
    .i_base     (i_addr_b),
    .i_stride   (i_stride_b),
    .i_mem_data (i_b_data),
    .o_mem_addr (o_b_addr),
    .o_lanes    (b_lanes)
  );

  pe_array #(.MAT_SIZE(MAT_SIZE)) u_pe_array (
    .clk        (clk),
    .reset      (reset),
    .i_pe_reset (i_pe_reset),
    .i_a_lanes  (a_lanes),
    .i_b_lanes  (b_lanes),
    .o_sums     (sums)
  );

  result_drain #(.MAT_SIZE(MAT_SIZE)) u_result_drain (
    .clk        (clk),
    .reset      (reset),
    .i_running  (running),
    .i_latch    (latch),
    .i_addr_c   (i_addr_c),
    .i_stride_c (i_stride_c),
    .i_sums     (sums),
    .o_c_data   (o_c_data),
    .o_c_addr   (o_c_addr),
    .o_c_valid  (o_c_valid)
  );

endmodule

`default_nettype wire

/* tests/matmul_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module matmul_checker #(
  parameter int MAT_SIZE = 4
) (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       i_start,
  input  logic                                       i_c_valid,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_c_data,
  input  matmul_pkg::addr_t                          i_c_addr,
  input  logic                                       i_done,
  output int                                         o_fail_count
);
  import matmul_pkg::*;

  localparam int ROW_W     = MAT_SIZE * DATA_WIDTH;
  localparam int MAT_W     = MAT_SIZE * MAT_SIZE * DATA_WIDTH;
  // Cycles of column 0 and of the done pulse counted from the first start cycle
  localparam int FIRST_COL = 3 * MAT_SIZE + 3;
  localparam int DONE_CYC  = 4 * MAT_SIZE + 3;

  logic [MAT_W-1:0] exp_a = '0;
  logic [MAT_W-1:0] exp_b = '0;
  addr_t            c_base = '0;
  stride_t          c_stride = '0;
  logic [ROW_W-1:0] got_col  [MAT_SIZE];
  addr_t            got_addr [MAT_SIZE];

  int run_cyc      = 0;
  int col_cnt      = 0;
  int done_cnt     = 0;
  int done_cyc     = 0;
  int test_errors  = 0;
  int total_errors = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  assign o_fail_count = total_errors;

  task automatic flag_error(input string msg);
    $display("error: %s", msg);
    test_errors++;
    total_errors++;
  endtask

  // Expected matrices and C placement for the next operation
  task automatic load_test(input logic [MAT_W-1:0] a, input logic [MAT_W-1:0] b,
                           input addr_t base, input stride_t stride);
    exp_a    = a;
    exp_b    = b;
    c_base   = base;
    c_stride = stride;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Each product clamps to one element before the sum wraps at 8 bits
  function automatic data_t ref_elem(input int i, input int j);
    int acc;
    int prod;
    data_t a_ik;
    data_t b_kj;
    acc = 0;
    for (int k = 0; k < MAT_SIZE; k++) begin
      a_ik = data_t'(exp_a[(i*MAT_SIZE+k)*DATA_WIDTH +: DATA_WIDTH]);
      b_kj = data_t'(exp_b[(k*MAT_SIZE+j)*DATA_WIDTH +: DATA_WIDTH]);
      prod = int'(a_ik) * int'(b_kj);
      if (prod > 127) begin
        prod = 127;
      end else if (prod < -128) begin
        prod = -128;
      end
      acc = acc + prod;
    end
    return data_t'(acc);
  endfunction

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  // Sampled at the rising edge so the values seen belong to the cycle that ends
  always @(posedge clk) begin
    if (reset) begin
      run_cyc = 0;
    end else if (!i_start) begin
      run_cyc = 0;
      if (i_c_valid !== 1'b0) begin
        flag_error("o_c_valid is not low while i_start is low");
      end
      if (i_done !== 1'b0) begin
        flag_error("o_done is not low while i_start is low");
      end
    end else begin
      if (i_c_valid) begin
        if (col_cnt >= MAT_SIZE) begin
          flag_error($sformatf("extra result column in cycle %0d", run_cyc));
        end else begin
          if (run_cyc != FIRST_COL + col_cnt) begin
            flag_error($sformatf("column %0d arrived in cycle %0d instead of cycle %0d",
                                 col_cnt, run_cyc, FIRST_COL + col_cnt));
          end
          got_col[col_cnt]  = i_c_data;
          got_addr[col_cnt] = i_c_addr;
        end
        col_cnt++;
      end
      if (i_done) begin
        done_cnt++;
        done_cyc = run_cyc;
      end
      run_cyc++;
    end
  end

  //////////////////////////////////////////////////
  // Per test comparison
  //////////////////////////////////////////////////

  task automatic end_test(input string name, input bit expect_run);
    data_t exp_val;
    data_t act_val;
    addr_t exp_addr;
    if (expect_run) begin
      if (col_cnt != MAT_SIZE) begin
        flag_error($sformatf("test %s gave %0d result columns instead of %0d",
                             name, col_cnt, MAT_SIZE));
      end
      if (done_cnt == 0) begin
        flag_error($sformatf("test %s ended without a done pulse", name));
      end else if (done_cnt > 1) begin
        flag_error($sformatf("test %s saw %0d done cycles instead of one", name, done_cnt));
      end else if (done_cyc < DONE_CYC) begin
        flag_error($sformatf("test %s raised done early, in cycle %0d instead of %0d",
                             name, done_cyc, DONE_CYC));
      end else if (done_cyc > DONE_CYC) begin
        flag_error($sformatf("test %s raised done late, in cycle %0d instead of %0d",
                             name, done_cyc, DONE_CYC));
      end
      for (int j = 0; j < MAT_SIZE && j < col_cnt; j++) begin
        exp_addr = addr_t'(c_base + j * c_stride);
        if (got_addr[j] !== exp_addr) begin
          $display("mismatch in %s: address of column %0d expected 0x%0h actual 0x%0h",
                   name, j, exp_addr, got_addr[j]);
          test_errors++;
          total_errors++;
        end
        for (int i = 0; i < MAT_SIZE; i++) begin
          exp_val = ref_elem(i, j);
          act_val = data_t'(got_col[j][i*DATA_WIDTH +: DATA_WIDTH]);
          if (act_val !== exp_val) begin
            $display("mismatch in %s: C[%0d][%0d] expected %0d actual %0d",
                     name, i, j, exp_val, act_val);
            test_errors++;
            total_errors++;
          end
        end
      end
    end else if (col_cnt != 0 || done_cnt != 0) begin
      flag_error($sformatf("test %s saw result activity without a start", name));
    end
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAIL",
             test_errors);
    col_cnt     = 0;
    done_cnt    = 0;
    done_cyc    = 0;
    test_errors = 0;
  endtask

  task automatic report_summary();
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, total_errors);
  endtask

endmodule

`default_nettype wire

/* tests/tb_systolic_matmul.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_systolic_matmul;
  import matmul_pkg::*;

  localparam int MAT_SIZE       = 4;
  localparam int ROW_W          = MAT_SIZE * DATA_WIDTH;
  localparam int MAT_W          = MAT_SIZE * MAT_SIZE * DATA_WIDTH;
  localparam int MEM_DEPTH      = 2 ** ADDR_WIDTH;
  // Five operations of about 25 cycles plus reset and idle time and a wide margin
  localparam int TIMEOUT_CYCLES = 400;

  logic    clk = 1'b0;
  logic    reset;
  logic    start;
  logic    pe_reset;
  addr_t   addr_a;
  addr_t   addr_b;
  addr_t   addr_c;
  stride_t stride_a;
  stride_t stride_b;
  stride_t stride_c;
  logic [ROW_W-1:0] a_data = '0;
  logic [ROW_W-1:0] b_data = '0;
  addr_t            o_a_addr;
  addr_t            o_b_addr;
  addr_t            o_c_addr;
  logic [ROW_W-1:0] o_c_data;
  logic             o_c_valid;
  logic             o_done;
  int               fail_count;

  // Operand memories and the read address each one captured
  logic [ROW_W-1:0] mem_a [MEM_DEPTH];
  logic [ROW_W-1:0] mem_b [MEM_DEPTH];
  addr_t            a_rd_addr = '0;
  addr_t            b_rd_addr = '0;

  // Current matrices with element (r, c) at index r*N+c
  logic [MAT_W-1:0] mat_a;
  logic [MAT_W-1:0] mat_b;
  integer           seed;
  int               cycle_cnt = 0;

  systolic_matmul #(.MAT_SIZE(MAT_SIZE)) u_systolic_matmul (
    .clk        (clk),
    .reset      (reset),
    .i_start    (start),
    .i_pe_reset (pe_reset),
    .i_addr_a   (addr_a),
    .i_addr_b   (addr_b),
    .i_addr_c   (addr_c),
    .i_stride_a (stride_a),
    .i_stride_b (stride_b),
    .i_stride_c (stride_c),
    .i_a_data   (a_data),
    .i_b_data   (b_data),
    .o_a_addr   (o_a_addr),
    .o_b_addr   (o_b_addr),
    .o_c_addr   (o_c_addr),
    .o_c_data   (o_c_data),
    .o_c_valid  (o_c_valid),
    .o_done     (o_done)
  );

  matmul_checker #(.MAT_SIZE(MAT_SIZE)) u_checker (
    .clk          (clk),
    .reset        (reset),
    .i_start      (start),
    .i_c_valid    (o_c_valid),
    .i_c_data     (o_c_data),
    .i_c_addr     (o_c_addr),
    .i_done       (o_done),
    .o_fail_count (fail_count)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Memory models and timeout
  //////////////////////////////////////////////////

  // Each memory captures the address at the rising edge and drives the word at the next
  // falling edge
  always @(posedge clk) begin
    a_rd_addr <= o_a_addr;
    b_rd_addr <= o_b_addr;
  end

  always @(negedge clk) begin
    a_data <= mem_a[a_rd_addr];
    b_data <= mem_b[b_rd_addr];
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Background words mix all address bits so a wrong read shows up
  function automatic logic [ROW_W-1:0] fill_word(input int addr, input int salt);
    logic [ROW_W-1:0] word;
    for (int l = 0; l < MAT_SIZE; l++) begin
      word[l*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'((addr ^ (addr >> 3)) + l * 37 + salt);
    end
    return word;
  endfunction

  task automatic set_a(input int r, input int c, input int v);
    mat_a[(r*MAT_SIZE+c)*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(v);
  endtask

  task automatic set_b(input int r, input int c, input int v);
    mat_b[(r*MAT_SIZE+c)*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(v);
  endtask

  //////////////////////////////////////////////////
  // Matrix patterns
  //////////////////////////////////////////////////

  // Largest sum is 4*7*4 so nothing clamps or wraps
  task automatic make_small();
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int c = 0; c < MAT_SIZE; c++) begin
        set_a(r, c, r + c + 1);
        set_b(r, c, (r + 2 * c) % 4 + 1);
      end
    end
  endtask

  task automatic make_random();
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int c = 0; c < MAT_SIZE; c++) begin
        set_a(r, c, $random(seed));
        set_b(r, c, $random(seed));
      end
    end
  endtask

  // Products such as 127*127 and -128*-128 clamp before the sum
  task automatic make_limits();
    int pick;
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int c = 0; c < MAT_SIZE; c++) begin
        set_a(r, c, ((r + c) % 2 == 0) ? 127 : -128);
        pick = (r + 2 * c) % 4;
        set_b(r, c, (pick == 1) ? -128 : ((pick == 2) ? -1 : 127));
      end
    end
  endtask

  // Word k of A holds column k of A and word k of B holds row k of B
  task automatic load_matrices(input addr_t base_a, input stride_t step_a,
                               input addr_t base_b, input stride_t step_b,
                               input addr_t base_c, input stride_t step_c);
    logic [ROW_W-1:0] word_a;
    logic [ROW_W-1:0] word_b;
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int l = 0; l < MAT_SIZE; l++) begin
        word_a[l*DATA_WIDTH +: DATA_WIDTH] = mat_a[(l*MAT_SIZE+k)*DATA_WIDTH +: DATA_WIDTH];
        word_b[l*DATA_WIDTH +: DATA_WIDTH] = mat_b[(k*MAT_SIZE+l)*DATA_WIDTH +: DATA_WIDTH];
      end
      mem_a[addr_t'(base_a + k * step_a)] = word_a;
      mem_b[addr_t'(base_b + k * step_b)] = word_b;
    end
    addr_a   = base_a;
    addr_b   = base_b;
    addr_c   = base_c;
    stride_a = step_a;
    stride_b = step_b;
    stride_c = step_c;
    u_checker.load_test(mat_a, mat_b, base_c, step_c);
  endtask

  // Start stays high until one cycle after done and then the sums are cleared
  task automatic run_multiply(input string name);
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    while (!o_done) begin
      @(negedge clk);
    end
    @(negedge clk);
    start = 1'b0;
    @(negedge clk);
    pe_reset = 1'b1;
    @(negedge clk);
    pe_reset = 1'b0;
    u_checker.end_test(name, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    seed     = 32'ha88e;
    reset    = 1'b1;
    start    = 1'b0;
    pe_reset = 1'b0;
    addr_a   = '0;
    addr_b   = '0;
    addr_c   = '0;
    stride_a = 8'd1;
    stride_b = 8'd1;
    stride_c = 8'd1;
    mat_a    = '0;
    mat_b    = '0;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      mem_a[a] = fill_word(a, 0);
      mem_b[a] = fill_word(a * 3, 91);
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // Outputs stay quiet with start low
    repeat (8) @(negedge clk);
    u_checker.end_test("idle_after_reset", 1'b0);

    make_small();
    load_matrices(11'h000, 8'd1, 11'h100, 8'd1, 11'h000, 8'd1);
    run_multiply("small_positive");

    make_random();
    load_matrices(11'h000, 8'd1, 11'h100, 8'd1, 11'h000, 8'd1);
    run_multiply("random_signed");

    make_limits();
    load_matrices(11'h000, 8'd1, 11'h100, 8'd1, 11'h000, 8'd1);
    run_multiply("saturation_limits");

    // B addresses wrap past the top of the memory
    make_random();
    load_matrices(11'h123, 8'd5, 11'h7f0, 8'h21, 11'h040, 8'd3);
    run_multiply("bases_and_strides");

    make_random();
    load_matrices(11'h000, 8'd1, 11'h100, 8'd1, 11'h000, 8'd1);
    run_multiply("after_pe_reset");

    repeat (2) @(negedge clk);
    u_checker.report_summary();
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
design/matmul_pkg.sv
design/processing_element.sv
design/pe_array.sv
design/operand_fetch.sv
design/matmul_sequencer.sv
design/result_drain.sv
design/systolic_matmul.sv
tests/matmul_checker.sv
tests/tb_systolic_matmul.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the systolic matrix multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_systolic_matmul -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
